// ==== common/inval_pkg.sv ====
package inval_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // AXI AW channel widths
  ////////////////////////////////////////////////////////////////////////////

  // Byte address
  localparam int unsigned ADDR_WIDTH = 32;
  // Burst length field, burst has len+1 beats
  localparam int unsigned LEN_WIDTH  = 8;
  // Beat size field, 2**size bytes per beat
  localparam int unsigned SIZE_WIDTH = 3;

  // Burst byte span, up to 256 beats of 128 bytes
  localparam int unsigned SPAN_WIDTH = 16;

  ////////////////////////////////////////////////////////////////////////////
  // L1 geometry
  ////////////////////////////////////////////////////////////////////////////

  // Line size, sized to the span arithmetic
  localparam logic [SPAN_WIDTH-1:0] LINE_BYTES = 16'd16;
  localparam int unsigned LINE_OFFSET_BITS = 4;
  // Direct mapped, index is addr[7:4], tag is addr[31:8]
  localparam int unsigned NUM_LINES  = 16;
  localparam int unsigned INDEX_BITS = 4;
  localparam int unsigned TAG_BITS   = ADDR_WIDTH - INDEX_BITS - LINE_OFFSET_BITS;

  // Outstanding AW bursts held for invalidation
  localparam int unsigned MAX_TXNS = 4;

  // One captured AW, 43 bits
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0]  len;
    logic [SIZE_WIDTH-1:0] size;
  } aw_beat_t;

endpackage

// ==== hdl/fifo_fall_through.sv ====
module fifo_fall_through #(
  parameter int unsigned DEPTH = 2,
  parameter type         dtype = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  dtype data_i,
  input  logic pop_i,
  output dtype data_o,
  output logic full_o,
  output logic empty_o
);

  // Storage, payload only
  dtype mem_q [DEPTH];

  logic [$clog2(DEPTH)-1:0] rd_ptr_q, wr_ptr_q;
  logic [$clog2(DEPTH):0]   count_q;

  logic stored_empty;
  logic write_en;
  logic read_en;

  assign stored_empty = (count_q == '0);
  assign full_o       = (count_q == DEPTH);
  // Head is valid in the push cycle when bypassing
  assign empty_o      = stored_empty & ~push_i;

  // Bypassed beat consumed in the same cycle never lands in storage
  assign write_en = push_i & ~(stored_empty & pop_i);
  assign read_en  = pop_i & ~stored_empty;

  // Head selection
  always_comb begin
    data_o = mem_q[rd_ptr_q];
    if (stored_empty) begin
      data_o = data_i;
    end
  end

  // Pointers and fill level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (write_en) begin
        wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (read_en) begin
        rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      if (write_en && !read_en) begin
        count_q <= count_q + 1'b1;
      end else if (read_en && !write_en) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (write_en) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Producer and consumer must respect the flags
  assert property (@(posedge clk_i) disable iff (!rst_ni) full_o |-> !push_i);
  assert property (@(posedge clk_i) disable iff (!rst_ni) empty_o |-> !pop_i);

endmodule

// ==== inval_filter/aw_capture.sv ====
module aw_capture (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             en_i,
  // Slave side AW
  input  logic                             slv_aw_valid_i,
  input  logic [inval_pkg::ADDR_WIDTH-1:0] slv_aw_addr_i,
  input  logic [inval_pkg::LEN_WIDTH-1:0]  slv_aw_len_i,
  input  logic [inval_pkg::SIZE_WIDTH-1:0] slv_aw_size_i,
  output logic                             slv_aw_ready_o,
  // Master side AW
  output logic                             mst_aw_valid_o,
  output logic [inval_pkg::ADDR_WIDTH-1:0] mst_aw_addr_o,
  output logic [inval_pkg::LEN_WIDTH-1:0]  mst_aw_len_o,
  output logic [inval_pkg::SIZE_WIDTH-1:0] mst_aw_size_o,
  input  logic                             mst_aw_ready_i,
  // Transaction FIFO head
  input  logic                             pop_i,
  output inval_pkg::aw_beat_t              head_beat_o,
  output logic                             head_valid_o
);

  logic                fifo_full;
  logic                fifo_empty;
  logic                aw_push;
  inval_pkg::aw_beat_t aw_beat;

  ////////////////////////////////////////////////////////////////////////////
  // AW pass-through
  ////////////////////////////////////////////////////////////////////////////

  // Stall both directions while no slot is free
  assign mst_aw_valid_o = slv_aw_valid_i & ~fifo_full;
  assign slv_aw_ready_o = mst_aw_ready_i & ~fifo_full;

  assign mst_aw_addr_o = slv_aw_addr_i;
  assign mst_aw_len_o  = slv_aw_len_i;
  assign mst_aw_size_o = slv_aw_size_i;

  ////////////////////////////////////////////////////////////////////////////
  // Capture of accepted bursts
  ////////////////////////////////////////////////////////////////////////////

  // Record only while snooping is on
  assign aw_push = en_i & slv_aw_valid_i & slv_aw_ready_o;

  assign aw_beat.addr = slv_aw_addr_i;
  assign aw_beat.len  = slv_aw_len_i;
  assign aw_beat.size = slv_aw_size_i;

  fifo_fall_through #(
    .DEPTH (inval_pkg::MAX_TXNS),
    .dtype (inval_pkg::aw_beat_t)
  ) i_aw_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (aw_push),
    .data_i  (aw_beat),
    .pop_i   (pop_i),
    .data_o  (head_beat_o),
    .full_o  (fifo_full),
    .empty_o (fifo_empty)
  );

  assign head_valid_o = ~fifo_empty;

  // Upstream keeps a stalled AW steady
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (slv_aw_valid_i && !slv_aw_ready_o) |=> (slv_aw_valid_i && $stable(slv_aw_addr_i)));

endmodule

// ==== inval_filter/burst_decode.sv ====
module burst_decode (
  input  inval_pkg::aw_beat_t              head_beat_i,
  output logic [inval_pkg::SPAN_WIDTH-1:0] first_offset_o,
  output logic [inval_pkg::SPAN_WIDTH-1:0] span_o,
  output logic                             multi_line_o
);

  // Byte position of the burst start inside its line
  logic [inval_pkg::LINE_OFFSET_BITS-1:0] line_pos;
  logic [inval_pkg::SPAN_WIDTH-1:0]       line_pos_ext;
  // Beat count, len + 1
  logic [inval_pkg::SPAN_WIDTH-1:0]       len_ext;
  logic [inval_pkg::SPAN_WIDTH-1:0]       beats;

  ////////////////////////////////////////////////////////////////////////////
  // First line
  ////////////////////////////////////////////////////////////////////////////

  assign line_pos = head_beat_i.addr[inval_pkg::LINE_OFFSET_BITS-1:0];

  assign line_pos_ext = {
    {(inval_pkg::SPAN_WIDTH - inval_pkg::LINE_OFFSET_BITS){1'b0}},
    line_pos
  };

  // Distance from start to the next line boundary
  // Full line when aligned
  assign first_offset_o = inval_pkg::LINE_BYTES - line_pos_ext;

  ////////////////////////////////////////////////////////////////////////////
  // Burst span
  ////////////////////////////////////////////////////////////////////////////

  assign len_ext = {
    {(inval_pkg::SPAN_WIDTH - inval_pkg::LEN_WIDTH){1'b0}},
    head_beat_i.len
  };

  assign beats = len_ext + 1'b1;

  // Bytes covered, beats scaled by beat size
  // Worst case 256 x 128 still fits
  assign span_o = beats << head_beat_i.size;

  // Burst reaches past its first line
  assign multi_line_o = (first_offset_o < span_o);

endmodule

// ==== inval_filter/line_walker.sv ====
module line_walker (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             head_valid_i,
  input  logic [inval_pkg::ADDR_WIDTH-1:0] head_addr_i,
  input  logic [inval_pkg::SPAN_WIDTH-1:0] first_offset_i,
  input  logic [inval_pkg::SPAN_WIDTH-1:0] span_i,
  input  logic                             multi_line_i,
  input  logic                             inval_ready_i,
  output logic                             inval_valid_o,
  output logic [inval_pkg::ADDR_WIDTH-1:0] inval_addr_o,
  output logic                             pop_o,
  output logic                             idle_o
);

  typedef enum logic {
    Idle,
    Invalidating
  } state_e;

  state_e state_d, state_q;

  // Byte offset of the current line from the burst start
  logic [inval_pkg::SPAN_WIDTH-1:0] offset_d, offset_q;
  logic [inval_pkg::SPAN_WIDTH-1:0] offset_next;
  logic [inval_pkg::ADDR_WIDTH-1:0] offset_ext;
  logic                             accept;

  ////////////////////////////////////////////////////////////////////////////
  // Request
  ////////////////////////////////////////////////////////////////////////////

  assign offset_ext = {{(inval_pkg::ADDR_WIDTH - inval_pkg::SPAN_WIDTH){1'b0}}, offset_q};

  // Live as soon as the FIFO head shows up
  assign inval_valid_o = head_valid_i;
  assign inval_addr_o  = head_addr_i + offset_ext;
  assign accept        = inval_valid_o & inval_ready_i;

  // Nothing queued and nothing in flight
  assign idle_o = (state_q == Idle) & ~head_valid_i;

  assign offset_next = offset_q + inval_pkg::LINE_BYTES;

  ////////////////////////////////////////////////////////////////////////////
  // Walker FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d  = state_q;
    offset_d = offset_q;
    pop_o    = 1'b0;

    unique case (state_q)
      Idle: begin
        if (accept) begin
          // First line done, more to go
          if (multi_line_i) begin
            state_d  = Invalidating;
            offset_d = first_offset_i;
          end else begin
            pop_o = 1'b1;
          end
        end
      end

      Invalidating: begin
        if (accept) begin
          offset_d = offset_next;
          // Last line covered
          if (offset_next >= span_i) begin
            state_d  = Idle;
            offset_d = '0;
            pop_o    = 1'b1;
          end
        end
      end

      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= Idle;
      offset_q <= '0;
    end else begin
      state_q  <= state_d;
      offset_q <= offset_d;
    end
  end

  // Request held under back-pressure
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (inval_valid_o && !inval_ready_i) |=> (inval_valid_o && $stable(inval_addr_o)));

endmodule

// ==== hdl/l1_line_store.sv ====
module l1_line_store (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // Line fill, no handshake
  input  logic                             fill_valid_i,
  input  logic [inval_pkg::ADDR_WIDTH-1:0] fill_addr_i,
  // Invalidation requests
  input  logic                             inval_valid_i,
  input  logic [inval_pkg::ADDR_WIDTH-1:0] inval_addr_i,
  output logic                             inval_ready_o,
  // Lookup
  input  logic [inval_pkg::ADDR_WIDTH-1:0] lookup_addr_i,
  output logic                             lookup_hit_o
);

  logic [inval_pkg::NUM_LINES-1:0] valid_q;
  logic [inval_pkg::TAG_BITS-1:0]  tag_q [inval_pkg::NUM_LINES];

  logic [inval_pkg::INDEX_BITS-1:0] fill_idx, inval_idx, lookup_idx;
  logic [inval_pkg::TAG_BITS-1:0]   fill_tag, inval_tag, lookup_tag;
  logic                             inval_accept;

  // Address split
  assign fill_idx   = fill_addr_i[inval_pkg::LINE_OFFSET_BITS +: inval_pkg::INDEX_BITS];
  assign inval_idx  = inval_addr_i[inval_pkg::LINE_OFFSET_BITS +: inval_pkg::INDEX_BITS];
  assign lookup_idx = lookup_addr_i[inval_pkg::LINE_OFFSET_BITS +: inval_pkg::INDEX_BITS];
  assign fill_tag   = fill_addr_i[inval_pkg::ADDR_WIDTH-1 -: inval_pkg::TAG_BITS];
  assign inval_tag  = inval_addr_i[inval_pkg::ADDR_WIDTH-1 -: inval_pkg::TAG_BITS];
  assign lookup_tag = lookup_addr_i[inval_pkg::ADDR_WIDTH-1 -: inval_pkg::TAG_BITS];

  // Fill wins the array port
  assign inval_ready_o = ~fill_valid_i;
  assign inval_accept  = inval_valid_i & inval_ready_o;

  ////////////////////////////////////////////////////////////////////////////
  // Valid and tag arrays
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (fill_valid_i) begin
      valid_q[fill_idx] <= 1'b1;
    end else if (inval_accept && (tag_q[inval_idx] == inval_tag)) begin
      // Other tags at this index stay resident
      valid_q[inval_idx] <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_valid_i) begin
      tag_q[fill_idx] <= fill_tag;
    end
  end

  // Hit on valid line with matching tag
  assign lookup_hit_o = valid_q[lookup_idx] & (tag_q[lookup_idx] == lookup_tag);

  // Requests and fills arrive with a known address
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    inval_valid_i |-> !$isunknown(inval_addr_i));
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    fill_valid_i |-> !$isunknown(fill_addr_i));

endmodule

// ==== hdl/inval_filter_top.sv ====
module inval_filter_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             en_i,
  // AW from the master
  input  logic                             slv_aw_valid_i,
  input  logic [inval_pkg::ADDR_WIDTH-1:0] slv_aw_addr_i,
  input  logic [inval_pkg::LEN_WIDTH-1:0]  slv_aw_len_i,
  input  logic [inval_pkg::SIZE_WIDTH-1:0] slv_aw_size_i,
  output logic                             slv_aw_ready_o,
  // AW toward the slave
  output logic                             mst_aw_valid_o,
  output logic [inval_pkg::ADDR_WIDTH-1:0] mst_aw_addr_o,
  output logic [inval_pkg::LEN_WIDTH-1:0]  mst_aw_len_o,
  output logic [inval_pkg::SIZE_WIDTH-1:0] mst_aw_size_o,
  input  logic                             mst_aw_ready_i,
  // L1 side
  input  logic                             fill_valid_i,
  input  logic [inval_pkg::ADDR_WIDTH-1:0] fill_addr_i,
  input  logic [inval_pkg::ADDR_WIDTH-1:0] lookup_addr_i,
  output logic                             lookup_hit_o,
  output logic                             inval_idle_o
);

  inval_pkg::aw_beat_t              head_beat;
  logic                             head_valid;
  logic                             pop;
  logic [inval_pkg::SPAN_WIDTH-1:0] first_offset;
  logic [inval_pkg::SPAN_WIDTH-1:0] span;
  logic                             multi_line;
  logic                             inval_valid;
  logic                             inval_ready;
  logic [inval_pkg::ADDR_WIDTH-1:0] inval_addr;

  aw_capture i_aw_capture (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .en_i           (en_i),
    .slv_aw_valid_i (slv_aw_valid_i),
    .slv_aw_addr_i  (slv_aw_addr_i),
    .slv_aw_len_i   (slv_aw_len_i),
    .slv_aw_size_i  (slv_aw_size_i),
    .slv_aw_ready_o (slv_aw_ready_o),
    .mst_aw_valid_o (mst_aw_valid_o),
    .mst_aw_addr_o  (mst_aw_addr_o),
    .mst_aw_len_o   (mst_aw_len_o),
    .mst_aw_size_o  (mst_aw_size_o),
    .mst_aw_ready_i (mst_aw_ready_i),
    .pop_i          (pop),
    .head_beat_o    (head_beat),
    .head_valid_o   (head_valid)
  );

  burst_decode i_burst_decode (
    .head_beat_i    (head_beat),
    .first_offset_o (first_offset),
    .span_o         (span),
    .multi_line_o   (multi_line)
  );

  line_walker i_line_walker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .head_valid_i   (head_valid),
    .head_addr_i    (head_beat.addr),
    .first_offset_i (first_offset),
    .span_i         (span),
    .multi_line_i   (multi_line),
    .inval_ready_i  (inval_ready),
    .inval_valid_o  (inval_valid),
    .inval_addr_o   (inval_addr),
    .pop_o          (pop),
    .idle_o         (inval_idle_o)
  );

  l1_line_store i_l1_line_store (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fill_valid_i  (fill_valid_i),
    .fill_addr_i   (fill_addr_i),
    .inval_valid_i (inval_valid),
    .inval_addr_i  (inval_addr),
    .inval_ready_o (inval_ready),
    .lookup_addr_i (lookup_addr_i),
    .lookup_hit_o  (lookup_hit_o)
  );

endmodule

// ==== dv/tb_inval_filter.sv ====
module tb_inval_filter;

  localparam int CLK_PERIOD      = 100;
  localparam int SAMPLE_DELAY    = CLK_PERIOD / 4;
  localparam int RESET_CYCLES    = 4;
  // Cycle budget granted per golden line
  localparam int CYCLES_PER_LINE = 40;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        en;
  logic        slv_aw_valid;
  logic [31:0] slv_aw_addr;
  logic [7:0]  slv_aw_len;
  logic [2:0]  slv_aw_size;
  logic        slv_aw_ready;
  logic        mst_aw_valid;
  logic [31:0] mst_aw_addr;
  logic [7:0]  mst_aw_len;
  logic [2:0]  mst_aw_size;
  logic        mst_aw_ready;
  logic        fill_valid;
  logic [31:0] fill_addr;
  logic [31:0] lookup_addr;
  logic        lookup_hit;
  logic        inval_idle;

  int seed;
  int cycle_count = 0;
  int cycle_limit = 0;

  // AWs issued on the slave side, oldest first
  inval_pkg::aw_beat_t exp_aw_q[$];
  inval_pkg::aw_beat_t mon_beat;

  inval_filter_top UUT (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .en_i           (en),
    .slv_aw_valid_i (slv_aw_valid),
    .slv_aw_addr_i  (slv_aw_addr),
    .slv_aw_len_i   (slv_aw_len),
    .slv_aw_size_i  (slv_aw_size),
    .slv_aw_ready_o (slv_aw_ready),
    .mst_aw_valid_o (mst_aw_valid),
    .mst_aw_addr_o  (mst_aw_addr),
    .mst_aw_len_o   (mst_aw_len),
    .mst_aw_size_o  (mst_aw_size),
    .mst_aw_ready_i (mst_aw_ready),
    .fill_valid_i   (fill_valid),
    .fill_addr_i    (fill_addr),
    .lookup_addr_i  (lookup_addr),
    .lookup_hit_o   (lookup_hit),
    .inval_idle_o   (inval_idle)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Error reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic end_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("FAILED at time %0t: %s expected 0x%0h, actual 0x%0h",
             $time, name, expected, actual);
    end_with_failure();
  endtask

  task automatic report_problem(input string msg);
    $display("Error at time %0t: %s", $time, msg);
    end_with_failure();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus, all driven on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_quiet();
    slv_aw_valid = 1'b0;
    fill_valid   = 1'b0;
  endtask

  task automatic fill_line(input logic [31:0] addr);
    @(negedge clk);
    drive_quiet();
    fill_valid = 1'b1;
    fill_addr  = addr;
  endtask

  task automatic set_enable(input logic value);
    @(negedge clk);
    drive_quiet();
    en = value;
  endtask

  // Holds the AW until accepted, ready toggles randomly meanwhile
  task automatic send_aw(input logic [31:0] addr, input logic [7:0] len,
                         input logic [2:0] size);
    inval_pkg::aw_beat_t beat;
    bit accepted;
    beat.addr = addr;
    beat.len  = len;
    beat.size = size;
    exp_aw_q.push_back(beat);
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      fill_valid   = 1'b0;
      slv_aw_valid = 1'b1;
      slv_aw_addr  = addr;
      slv_aw_len   = len;
      slv_aw_size  = size;
      // Ready in about three cycles of four
      mst_aw_ready = (($random(seed) & 3) != 0);
      #SAMPLE_DELAY;
      accepted = slv_aw_valid && slv_aw_ready;
    end
  endtask

  task automatic wait_idle();
    bit idle_seen;
    idle_seen = 1'b0;
    while (!idle_seen) begin
      @(negedge clk);
      drive_quiet();
      #SAMPLE_DELAY;
      idle_seen = inval_idle;
    end
  endtask

  task automatic check_lookup(input logic [31:0] addr, input logic exp_hit);
    @(negedge clk);
    drive_quiet();
    lookup_addr = addr;
    #SAMPLE_DELAY;
    assert (lookup_hit === exp_hit)
      else report_mismatch($sformatf("lookup_hit_o for 0x%08h", addr), exp_hit, lookup_hit);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Master side monitor and timeout
  ////////////////////////////////////////////////////////////////////////////

  // Every master AW must match the oldest slave AW
  always begin
    @(negedge clk);
    #SAMPLE_DELAY;
    if (mst_aw_valid && mst_aw_ready) begin
      assert (exp_aw_q.size() != 0)
        else report_problem("master side issued an AW that was never sent");
      mon_beat = exp_aw_q.pop_front();
      assert (mst_aw_addr === mon_beat.addr)
        else report_mismatch("mst_aw_addr_o", mon_beat.addr, mst_aw_addr);
      assert (mst_aw_len === mon_beat.len)
        else report_mismatch("mst_aw_len_o", mon_beat.len, mst_aw_len);
      assert (mst_aw_size === mon_beat.size)
        else report_mismatch("mst_aw_size_o", mon_beat.size, mst_aw_size);
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    assert (cycle_count <= cycle_limit)
      else report_problem($sformatf("timeout, test still running after %0d cycles",
                                    cycle_limit));
  end

  ////////////////////////////////////////////////////////////////////////////
  // Golden file sequencer
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main_seq
    int               fd;
    int               code;
    int               line_count;
    logic [7:0]       op;
    logic [31:0]      arg_a;
    logic [31:0]      arg_b;
    logic [31:0]      arg_c;
    logic [8*256-1:0] line_buf;

    seed         = 25;
    rst_n        = 1'b0;
    en           = 1'b0;
    slv_aw_valid = 1'b0;
    slv_aw_addr  = '0;
    slv_aw_len   = '0;
    slv_aw_size  = '0;
    mst_aw_ready = 1'b1;
    fill_valid   = 1'b0;
    fill_addr    = '0;
    lookup_addr  = '0;

    // Size the timeout from the file length
    line_count = 0;
    fd = $fopen("dv/inval_golden.txt", "r");
    assert (fd != 0) else report_problem("cannot open dv/inval_golden.txt");
    while ($fgets(line_buf, fd) != 0) begin
      line_count++;
    end
    $fclose(fd);
    cycle_limit = CYCLES_PER_LINE * line_count + RESET_CYCLES;

    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    // Empty FIFO, walker idle
    #SAMPLE_DELAY;
    assert (inval_idle === 1'b1) else report_mismatch("inval_idle_o", 1, inval_idle);
    assert (slv_aw_ready === mst_aw_ready)
      else report_mismatch("slv_aw_ready_o", mst_aw_ready, slv_aw_ready);

    fd   = $fopen("dv/inval_golden.txt", "r");
    code = $fscanf(fd, " %c", op);
    while (code == 1) begin
      case (op)
        "#": code = $fgets(line_buf, fd);
        "F": begin
          code = $fscanf(fd, "%h", arg_a);
          assert (code == 1) else report_problem("F line needs an address");
          fill_line(arg_a);
        end
        "E": begin
          code = $fscanf(fd, "%h", arg_a);
          assert (code == 1) else report_problem("E line needs an enable bit");
          set_enable(arg_a[0]);
        end
        "W": begin
          code = $fscanf(fd, "%h %h %h", arg_a, arg_b, arg_c);
          assert (code == 3) else report_problem("W line needs addr, len and size");
          send_aw(arg_a, arg_b[7:0], arg_c[2:0]);
        end
        "Q": wait_idle();
        "L": begin
          code = $fscanf(fd, "%h %h", arg_a, arg_b);
          assert (code == 2) else report_problem("L line needs an address and a hit bit");
          check_lookup(arg_a, arg_b[0]);
        end
        default: report_problem($sformatf("unknown operation '%c' in golden file", op));
      endcase
      code = $fscanf(fd, " %c", op);
    end
    $fclose(fd);

    @(negedge clk);
    drive_quiet();
    #SAMPLE_DELAY;
    assert (exp_aw_q.size() == 0)
      else report_problem("some AWs never reached the master side");

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== dv/inval_golden.txt ====
# One operation per line, hex fields: F addr | E en | W addr len size | Q | L addr hit
# Q waits for inval_idle_o, L compares lookup_hit_o with hit
F 00001000
F 00001010
F 00001020
F 00001030
F 00001040
F 00001050
F 00001060
L 00001000 1
L 00001060 1
L 00002000 0
E 1
W 00001040 00 2
Q
L 00001040 0
L 00001030 1
L 00001050 1
W 00001008 07 2
Q
L 00001000 0
L 00001020 0
L 00001030 1
E 0
W 00001030 00 2
W 00001050 03 4
Q
L 00001030 1
L 00001060 1
E 1
W 00001030 00 2
W 00001040 03 4
W 00001000 03 4
W 00001080 03 4
W 000010c0 03 4
W 00001050 00 0
Q
L 00001030 0
L 00001050 0
L 00001060 0
F 00001050
F 00001060
W 00001048 03 3
F 00001000
F 00001010
Q
L 00001050 0
L 00001060 0
L 00001000 1
F 00001060
L 00001060 1

// ==== filelist.f ====
common/inval_pkg.sv
hdl/fifo_fall_through.sv
inval_filter/aw_capture.sv
inval_filter/burst_decode.sv
inval_filter/line_walker.sv
hdl/l1_line_store.sv
hdl/inval_filter_top.sv
dv/tb_inval_filter.sv

// ==== Bender.yml ====
package:
  name: inval_filter

sources:
  - common/inval_pkg.sv
  - hdl/fifo_fall_through.sv
  - inval_filter/aw_capture.sv
  - inval_filter/burst_decode.sv
  - inval_filter/line_walker.sv
  - hdl/l1_line_store.sv
  - hdl/inval_filter_top.sv
  - target: test
    files:
      - dv/tb_inval_filter.sv
